// ==== tb.f ====
+incdir+verilog
+incdir+bench
verilog/mem_pkg.sv
verilog/port_pkg.sv
verilog/fetch_port.sv
verilog/data_port.sv
verilog/word_store.sv
verilog/mem_system.sv
bench/tb_mem_system.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_mem_system
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv bench/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

`include "boot_image.svh"

// Shadow copy of the word store, updated when a write is accepted.
word_t shadow [MEM_WORDS];

task automatic model_reset();
    for (int i = 0; i < MEM_WORDS; i++) begin
        shadow[index_t'(i)] = '0;
    end
    for (int i = 0; i < BOOT_LEN; i++) begin
        shadow[index_t'(i)] = BOOT_WORDS[i];
    end
endtask

task automatic apply_write(input addr_t addr, input word_t data);
    shadow[index_t'(addr)] = data;      // Upper address bits ignored.
endtask

function automatic word_t expected_word(input addr_t addr);
    return shadow[index_t'(addr)];
endfunction

// A write accepted in the same cycle shows up in the fetched line.
function automatic line_t expected_line(input addr_t fetch_addr, input logic wr,
                                        input addr_t wr_addr, input word_t wr_data);
    line_t  result;
    index_t base;
    index_t idx;
    base = index_t'(fetch_addr) & ~index_t'(LINE_WORDS - 1);
    for (int w = 0; w < LINE_WORDS; w++) begin
        idx = base + index_t'(w);
        if (wr && index_t'(wr_addr) == idx) begin
            result[w] = wr_data;
        end else begin
            result[w] = shadow[idx];
        end
    end
    return result;
endfunction

task automatic compare_line(input line_t got, input line_t expected);
    if (got !== expected) begin
        fail_run($sformatf("error at %0t ns: fetch line %h, expected %h",
                           $time, got, expected));
    end
endtask

task automatic compare_word(input word_t got, input word_t expected);
    if (got !== expected) begin
        fail_run($sformatf("error at %0t ns: data word %h, expected %h",
                           $time, got, expected));
    end
endtask

task automatic compare_ready(input string port, input logic ready, input logic busy,
                             input int unsigned age);
    if (ready && !busy) begin
        fail_run($sformatf("%s ready pulsed with no access in flight", port));
    end else if (ready && age != ACCESS_LATENCY) begin
        fail_run($sformatf("%s ready came %0d cycles after the request instead of %0d",
                           port, age, ACCESS_LATENCY));
    end else if (!ready && busy && age >= ACCESS_LATENCY) begin
        fail_run($sformatf("%s ready missing %0d cycles after the request", port, age));
    end
endtask

`endif

// ==== bench/tb_mem_system.sv ====
`timescale 1ns/1ps

module tb_mem_system
    import mem_pkg::*, port_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 4;
    localparam int BOOT_LINES = 10;     // Runs past BOOT_LEN into zeros.
    localparam int RW_COUNT = 12;
    localparam int HELD_PULSES = 3;
    localparam int MIX_COUNT = 40;

    // Mixed traffic is counted on both ports.
    localparam int REQUEST_COUNT = BOOT_LINES + 2 * RW_COUNT + 2 * HELD_PULSES + 10
                                   + 2 * MIX_COUNT;
    localparam int WATCHDOG_CYCLES = 2 * (REQUEST_COUNT * (ACCESS_LATENCY + 2)
                                          + RESET_CYCLES);

    logic        clk;
    logic        reset_n;
    fetch_req_t  fetch_req;
    fetch_rsp_t  fetch_rsp;
    data_req_t   data_req;
    data_rsp_t   data_rsp;
    int unsigned cycle = 0;
    int          seed;

    // Accesses in flight as seen by the compare process.
    logic        fetch_busy = 1'b0;
    logic        data_busy = 1'b0;
    logic        data_is_read;
    int unsigned fetch_start;
    int unsigned data_start;
    line_t       fetch_expect;
    word_t       data_expect;
    logic        fetch_take;
    logic        data_take;
    logic        data_wr_take;

    addr_t       rw_addr [RW_COUNT];
    word_t       rw_data [RW_COUNT];
    addr_t       mix_faddr [MIX_COUNT];
    addr_t       mix_daddr [MIX_COUNT];
    word_t       mix_wdata [MIX_COUNT];
    logic [1:0]  mix_kind [MIX_COUNT];

    `include "tb_model.svh"

    mem_system uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    // Outputs and requests are sampled on the falling edge.
    always @(negedge clk) begin
        if (reset_n) begin
            fetch_take = !fetch_busy && fetch_req.req;
            data_take = !data_busy && (data_req.read || data_req.write);
            data_wr_take = data_take && !data_req.read;

            compare_ready("fetch", fetch_rsp.ready, fetch_busy, cycle - fetch_start);
            if (fetch_busy && fetch_rsp.ready) begin
                compare_line(fetch_rsp.line, fetch_expect);
                fetch_busy = 1'b0;
            end
            compare_ready("data", data_rsp.ready, data_busy, cycle - data_start);
            if (data_busy && data_rsp.ready) begin
                if (data_is_read) begin
                    compare_word(data_rsp.rdata, data_expect);
                end
                data_busy = 1'b0;
            end

            if (fetch_take) begin
                fetch_expect = expected_line(fetch_req.addr, data_wr_take,
                                             data_req.addr, data_req.wdata);
                fetch_start = cycle;
                fetch_busy = 1'b1;
            end
            if (data_take) begin
                data_is_read = data_req.read;       // Read wins over write.
                data_start = cycle;
                data_busy = 1'b1;
                if (data_req.read) begin
                    data_expect = expected_word(data_req.addr);
                end else begin
                    apply_write(data_req.addr, data_req.wdata);
                end
            end
        end
    end

    task automatic wait_fetch_ready(output int unsigned at);
        int n;
        n = 0;
        @(negedge clk);
        while (!fetch_rsp.ready) begin
            n++;
            if (n > ACCESS_LATENCY + 2) begin
                fail_run("fetch port never raised ready");
            end
            @(negedge clk);
        end
        at = cycle;
    endtask

    task automatic wait_data_ready(output int unsigned at);
        int n;
        n = 0;
        @(negedge clk);
        while (!data_rsp.ready) begin
            n++;
            if (n > ACCESS_LATENCY + 2) begin
                fail_run("data port never raised ready");
            end
            @(negedge clk);
        end
        at = cycle;
    endtask

    task automatic fetch_line(input addr_t addr);
        int unsigned at;
        @(posedge clk);
        fetch_req <= '{req: 1'b1, addr: addr};
        wait_fetch_ready(at);
        @(posedge clk);
        fetch_req.req <= 1'b0;
    endtask

    task automatic data_op(input logic rd, input logic wr, input addr_t addr,
                           input word_t wdata);
        int unsigned at;
        @(posedge clk);
        data_req <= '{read: rd, write: wr, addr: addr, wdata: wdata};
        wait_data_ready(at);
        @(posedge clk);
        data_req.read <= 1'b0;
        data_req.write <= 1'b0;
    endtask

    // Request stays high across several ready pulses.
    task automatic held_fetch(input addr_t addr, input int pulses);
        int unsigned at;
        int unsigned last;
        last = 0;
        @(posedge clk);
        fetch_req <= '{req: 1'b1, addr: addr};
        for (int k = 0; k < pulses; k++) begin
            wait_fetch_ready(at);
            if (k > 0 && at - last != ACCESS_LATENCY + 1) begin
                fail_run($sformatf("held fetch ready pulses came %0d cycles apart",
                                   at - last));
            end
            last = at;
        end
        @(posedge clk);
        fetch_req.req <= 1'b0;
    endtask

    task automatic held_read(input addr_t addr, input int pulses);
        int unsigned at;
        int unsigned last;
        last = 0;
        @(posedge clk);
        data_req <= '{read: 1'b1, write: 1'b0, addr: addr, wdata: '0};
        for (int k = 0; k < pulses; k++) begin
            wait_data_ready(at);
            if (k > 0 && at - last != ACCESS_LATENCY + 1) begin
                fail_run($sformatf("held read ready pulses came %0d cycles apart",
                                   at - last));
            end
            last = at;
        end
        @(posedge clk);
        data_req.read <= 1'b0;
    endtask

    initial begin
        seed = 32'h04e12897;
        reset_n = 1'b0;
        fetch_req = '0;
        data_req = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        if (fetch_rsp.ready || data_rsp.ready) begin
            fail_run("a ready output is high right after reset");
        end

        // Boot image and the cleared words above it.
        for (int i = 0; i < BOOT_LINES; i++) begin
            fetch_line(addr_t'(i * LINE_WORDS));
        end

        for (int i = 0; i < RW_COUNT; i++) begin
            rw_addr[i] = addr_t'($random(seed));
            rw_data[i] = word_t'($random(seed));
        end
        for (int i = 0; i < RW_COUNT; i++) begin
            data_op(1'b0, 1'b1, rw_addr[i], rw_data[i]);
        end
        for (int i = 0; i < RW_COUNT; i++) begin
            data_op(1'b1, 1'b0, rw_addr[i], '0);
        end

        held_fetch(16'h0008, HELD_PULSES);
        held_read(rw_addr[0], HELD_PULSES);

        // With both flags high the word must survive.
        data_op(1'b1, 1'b1, 16'h0030, 16'hdead);
        data_op(1'b1, 1'b0, 16'h0030, '0);

        fork
            data_op(1'b0, 1'b1, 16'h0082, 16'h5a5a);
            fetch_line(16'h0080);
        join
        fork
            data_op(1'b0, 1'b1, 16'h0081, 16'h1234);
            fetch_line(16'h0090);       // Unrelated line.
        join
        fetch_line(16'h0080);

        // Low byte kept small so writes often land in fetched lines.
        for (int i = 0; i < MIX_COUNT; i++) begin
            mix_faddr[i] = addr_t'($random(seed)) & 16'hff3f;
            mix_daddr[i] = addr_t'($random(seed)) & 16'hff3f;
            mix_wdata[i] = word_t'($random(seed));
            mix_kind[i] = 2'($random(seed));
        end
        fork
            begin
                for (int i = 0; i < MIX_COUNT; i++) begin
                    fetch_line(mix_faddr[i]);
                end
            end
            begin
                for (int i = 0; i < MIX_COUNT; i++) begin
                    data_op(mix_kind[i] != 2'd1, mix_kind[i] != 2'd0,
                            mix_daddr[i], mix_wdata[i]);
                end
            end
        join

        repeat (2) @(negedge clk);
        if (fetch_busy || data_busy) begin
            fail_run("run ended with an access still in flight");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== verilog/mem_system.sv ====
`timescale 1ns/1ps

module mem_system
    import mem_pkg::*, port_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  fetch_req_t fetch_req,
    output fetch_rsp_t fetch_rsp,
    input  data_req_t  data_req,
    output data_rsp_t  data_rsp
);

    store_access_t fetch_access;
    store_access_t data_access;
    line_t         store_line;
    word_t         store_word;

    // Instruction side.
    fetch_port u_fetch_port (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (fetch_req),
        .rsp     (fetch_rsp),
        .access  (fetch_access),
        .line    (store_line)
    );

    // Data side.
    data_port u_data_port (
        .clk     (clk),
        .reset_n (reset_n),
        .req     (data_req),
        .rsp     (data_rsp),
        .access  (data_access),
        .word    (store_word)
    );

    // Shared array serving both strobes in the same cycle.
    word_store u_word_store (
        .clk          (clk),
        .reset_n      (reset_n),
        .fetch_access (fetch_access),
        .data_access  (data_access),
        .line         (store_line),
        .word         (store_word)
    );

endmodule

// ==== verilog/word_store.sv ====
`timescale 1ns/1ps

`include "boot_image.svh"

module word_store
    import mem_pkg::*, port_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  store_access_t fetch_access,
    input  store_access_t data_access,
    output line_t         line,
    output word_t         word
);

    word_t mem [MEM_WORDS];

    logic [INDEX_BITS-LINE_SEL_BITS-1:0] line_base;
    index_t                              data_index;
    logic [LINE_SEL_BITS-1:0]            data_sel;
    logic                                data_write;
    logic                                forward_hit;
    line_t                               line_next;

    assign line_base = fetch_access.addr[INDEX_BITS-1:LINE_SEL_BITS];
    assign data_index = data_access.addr[INDEX_BITS-1:0];
    assign data_sel = data_access.addr[LINE_SEL_BITS-1:0];
    assign data_write = data_access.en && data_access.write;

    // Same-cycle write into the fetched line.
    assign forward_hit = data_write &&
                         (data_index[INDEX_BITS-1:LINE_SEL_BITS] == line_base);

    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            line_next[w] = mem[{line_base, LINE_SEL_BITS'(w)}];
        end
        if (forward_hit) begin
            line_next[data_sel] = data_access.wdata;
        end
    end

    // Boot image at the bottom and zero above it.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            for (int i = 0; i < BOOT_LEN; i++) begin
                mem[i] <= BOOT_WORDS[i];
            end
        end else if (data_write) begin
            mem[data_index] <= data_access.wdata;
        end
    end

    // Read registers hold until the next strobe on their port.
    always_ff @(posedge clk) begin
        if (fetch_access.en) begin
            line <= line_next;
        end
        if (data_access.en && !data_access.write) begin
            word <= mem[data_index];
        end
    end

    // The fetch controller only reads whole lines.
    a_fetch_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        fetch_access.en |-> fetch_access.addr[LINE_SEL_BITS-1:0] == '0
                            && !fetch_access.write);

endmodule

// ==== verilog/data_port.sv ====
`timescale 1ns/1ps

module data_port
    import mem_pkg::*, port_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  data_req_t     req,
    output data_rsp_t     rsp,
    output store_access_t access,
    input  word_t         word
);

    count_t count;
    logic   idle;
    logic   start;

    assign idle = (count == '0);
    assign start = (req.read || req.write) && idle;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= '0;
        end else if (start) begin
            count <= count_t'(ACCESS_LATENCY);
        end else if (!idle) begin
            count <= count - count_t'(1);
        end
    end

    // Read has priority over write.
    always_comb begin
        access.en = start;
        access.write = req.write && !req.read;
        access.addr = req.addr;
        access.wdata = req.wdata;
    end

    always_comb begin
        rsp.ready = (count == count_t'(1));
        rsp.rdata = word;       // Stale after a write.
    end

    // No second strobe while an access counts down.
    for (genvar k = 1; k <= ACCESS_LATENCY; k++) begin : g_gap
        a_no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
            access.en |-> !$past(access.en, k));
    end

    // Ready exactly ACCESS_LATENCY cycles after the strobe and never otherwise.
    a_ready_after_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        access.en |-> ##ACCESS_LATENCY rsp.ready);

    a_ready_only_at_end: assert property (@(posedge clk) disable iff (!reset_n)
        rsp.ready |-> $past(access.en, ACCESS_LATENCY));

endmodule

// ==== verilog/fetch_port.sv ====
`timescale 1ns/1ps

module fetch_port
    import mem_pkg::*, port_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  fetch_req_t    req,
    output fetch_rsp_t    rsp,
    output store_access_t access,
    input  line_t         line
);

    count_t count;
    logic   idle;

    assign idle = (count == '0);

    // Loaded on the strobe. Ready shows on the last count.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            count <= '0;
        end else if (access.en) begin
            count <= count_t'(ACCESS_LATENCY);
        end else if (!idle) begin
            count <= count - count_t'(1);
        end
    end

    always_comb begin
        access = '0;
        access.en = req.req && idle;
        access.addr = req.addr & ~addr_t'(LINE_WORDS - 1);    // Line aligned.
    end

    // Store holds the line until the next strobe.
    always_comb begin
        rsp.ready = (count == count_t'(1));
        rsp.line = line;
    end

    // A held request waits one idle cycle, so ready is a single pulse.
    a_ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        rsp.ready |=> !rsp.ready);

endmodule

// ==== verilog/port_pkg.sv ====
package port_pkg;

    import mem_pkg::*;

    // Instruction port reads whole lines only.
    typedef struct packed {
        logic  req;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  ready;
        line_t line;
    } fetch_rsp_t;

    // On the data port read wins when both flags are high.
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        logic  ready;
        word_t rdata;       // Only valid after a read.
    } data_rsp_t;

    // One-cycle strobe from a port controller into the word store.
    typedef struct packed {
        logic  en;
        logic  write;
        addr_t addr;
        word_t wdata;
    } store_access_t;

endpackage

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    // Storage geometry.
    localparam int MEM_WORDS = 256;
    localparam int LINE_WORDS = 4;      // Words per instruction line.
    localparam int WORD_BITS = 16;

    // Cycles from an accepted request to its ready pulse.
    localparam int ACCESS_LATENCY = 6;

    localparam int INDEX_BITS = $clog2(MEM_WORDS);
    localparam int LINE_SEL_BITS = $clog2(LINE_WORDS);
    localparam int COUNT_BITS = $clog2(ACCESS_LATENCY + 1);

    typedef logic [WORD_BITS-1:0] word_t;

    // Full 16-bit word address. Only the low INDEX_BITS select a word.
    typedef logic [15:0] addr_t;

    typedef logic [INDEX_BITS-1:0] index_t;

    // Word 0 of the line sits in the low bits.
    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef logic [COUNT_BITS-1:0] count_t;     // Latency down-counter.

endpackage

// ==== verilog/boot_image.svh ====
`ifndef BOOT_IMAGE_SVH
`define BOOT_IMAGE_SVH

// Boot program with word 0 first.
// Every word from BOOT_LEN upward resets to zero.
localparam int BOOT_LEN = 28;

localparam mem_pkg::word_t BOOT_WORDS [BOOT_LEN] = '{
    16'h9008, 16'h0001, 16'hffff, 16'h0000,
    16'h0000, 16'h0000, 16'h0000, 16'h0000,
    16'h6000, 16'hf01c, 16'h6100, 16'hf41c,
    16'h4401, 16'hf01c, 16'h5901, 16'hf41c,
    16'hf2c0, 16'hfc1c, 16'h7801, 16'h8901,
    16'h9016, 16'hf01d, 16'ha013, 16'h41ff,
    16'h2404, 16'h5001, 16'hf819, 16'hf01d
};

`endif
